/* hdl/lstm_pkg.sv */
`default_nettype none

package lstm_pkg;
        typedef logic signed [15:0] data_t;     // q4.12, 1.0 = 0x1000
        typedef logic signed [31:0] acc_t;      // q8.24 products and sums
        typedef logic [5:0]         addr_t;     // 64 word memory

        typedef enum logic [2:0] {
                gs_idle,
                gs_fetch_bias,
                gs_fetch_weight,
                gs_fetch_input,
                gs_accumulate,
                gs_finish
        } gate_state_t;

        localparam data_t Q_ONE = 16'sh1000;

        function automatic data_t q_from_acc(acc_t a);
                acc_t s;
                s = a >>> 12;                   // back to q4.12
                if (s > 32'sd32767)
                        return 16'sh7fff;
                else if (s < -32'sd32768)
                        return 16'sh8000;
                return s[15:0];
        endfunction

        function automatic data_t q_mul(data_t a, data_t b);
                acc_t p;
                p = a * b;
                return q_from_acc(p);
        endfunction

        function automatic data_t q_add_sat(data_t a, data_t b);
                logic signed [16:0] s;
                s = a + b;
                if (s[16] != s[15])
                        return s[16] ? 16'sh8000 : 16'sh7fff;
                return s[15:0];
        endfunction
endpackage

`default_nettype wire

/* hdl/sigmoid.sv */
`timescale 1ns/1ps
`default_nettype none

module sigmoid (
        input  lstm_pkg::data_t x,
        output lstm_pkg::data_t sig_out
);
        logic [5:0] bin;
        logic [5:0] address;

        // five 0.2 wide bins per integer step
        always_comb
        begin
                if (x[11:0] <= 12'h333)
                        bin = 6'd0;
                else if (x[11:0] <= 12'h666)
                        bin = 6'd1;
                else if (x[11:0] <= 12'h99a)
                        bin = 6'd2;
                else if (x[11:0] <= 12'hccd)
                        bin = 6'd3;
                else
                        bin = 6'd4;
        end

        always_comb
        begin
                case (x[15:12])
                4'hd:    address = 6'd8 + bin;          // -3.0 up to -2.0
                4'he:    address = 6'd13 + bin;
                4'hf:    address = 6'd18 + bin;
                4'h0:    address = 6'd23 + bin;
                4'h1:    address = 6'd28 + bin;
                4'h2:    address = 6'd33 + bin;
                4'h3:    address = 6'd38 + bin;         // up to 4.0
                4'h4, 4'h5, 4'h6, 4'h7:
                         address = 6'd49;               // clamps to 1.0
                default: address = 6'd48;               // below -3.0
                endcase
        end

        always_comb
        begin
                case (address)
                6'd0:    sig_out = 16'h002d;            // sig(-4.5)
                6'd1:    sig_out = 16'h0036;
                6'd2:    sig_out = 16'h0042;
                6'd3:    sig_out = 16'h0051;
                6'd4:    sig_out = 16'h0062;
                6'd5:    sig_out = 16'h0078;
                6'd6:    sig_out = 16'h0091;
                6'd7:    sig_out = 16'h00b0;
                6'd8:    sig_out = 16'h00d5;            // sig(-2.9)
                6'd9:    sig_out = 16'h0102;
                6'd10:   sig_out = 16'h0136;
                6'd11:   sig_out = 16'h0175;
                6'd12:   sig_out = 16'h01be;
                6'd13:   sig_out = 16'h0214;
                6'd14:   sig_out = 16'h0278;
                6'd15:   sig_out = 16'h02eb;
                6'd16:   sig_out = 16'h036d;
                6'd17:   sig_out = 16'h03fe;
                6'd18:   sig_out = 16'h04a0;
                6'd19:   sig_out = 16'h054f;
                6'd20:   sig_out = 16'h060a;
                6'd21:   sig_out = 16'h06cf;
                6'd22:   sig_out = 16'h0799;            // sig(-0.1)
                6'd23:   sig_out = 16'h0866;            // sig(0.1)
                6'd24:   sig_out = 16'h0930;
                6'd25:   sig_out = 16'h09f5;
                6'd26:   sig_out = 16'h0ab0;
                6'd27:   sig_out = 16'h0b60;
                6'd28:   sig_out = 16'h0c01;
                6'd29:   sig_out = 16'h0c92;
                6'd30:   sig_out = 16'h0d14;
                6'd31:   sig_out = 16'h0d87;
                6'd32:   sig_out = 16'h0deb;
                6'd33:   sig_out = 16'h0e41;
                6'd34:   sig_out = 16'h0e8a;
                6'd35:   sig_out = 16'h0ec9;
                6'd36:   sig_out = 16'h0efe;
                6'd37:   sig_out = 16'h0f2a;
                6'd38:   sig_out = 16'h0f4f;
                6'd39:   sig_out = 16'h0f6e;
                6'd40:   sig_out = 16'h0f87;
                6'd41:   sig_out = 16'h0f9d;
                6'd42:   sig_out = 16'h0fae;            // sig(3.9)
                6'd43:   sig_out = 16'h0fbd;
                6'd44:   sig_out = 16'h0fc9;
                6'd45:   sig_out = 16'h0fd3;
                6'd46:   sig_out = 16'h0fdb;
                6'd47:   sig_out = 16'h0024;            // sig(-4.7)
                6'd48:   sig_out = 16'h0000;
                6'd49:   sig_out = 16'h1000;
                default: sig_out = 16'h0000;
                endcase
        end
endmodule

`default_nettype wire

/* hdl/tanh_unit.sv */
`timescale 1ns/1ps
`default_nettype none

// tanh(x) = 2 * sig(2x) - 1
module tanh_unit (
        input  lstm_pkg::data_t x,
        output lstm_pkg::data_t tanh_out
);
        lstm_pkg::data_t x2;
        lstm_pkg::data_t sig_x2;

        assign x2 = lstm_pkg::q_add_sat(x, x);          // clamps past +-8

        sigmoid u_sig (
                .x       (x2),
                .sig_out (sig_x2)
        );

        // sig in [0, 1.0] so no overflow here
        assign tanh_out = lstm_pkg::q_add_sat(sig_x2, sig_x2) - lstm_pkg::Q_ONE;
endmodule

`default_nettype wire

/* hdl/weight_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module weight_mem (
        input  logic            clk,
        input  logic            reset,
        input  logic            cyc,
        input  logic            stb,
        input  logic            we,
        input  lstm_pkg::addr_t adr,
        input  lstm_pkg::data_t dat_w,
        output lstm_pkg::data_t dat_r,
        output logic            ack
);
        lstm_pkg::data_t mem [64];
        logic            req;

        assign req = cyc && stb && !ack;                // one wait state

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        ack <= 1'b0;
                        for (int k = 0; k < 64; k++)
                                mem[k] <= '0;
                end
                else
                begin
                        ack <= req;
                        if (req)
                        begin
                                dat_r <= mem[adr];      // old word on a write
                                if (we)
                                        mem[adr] <= dat_w;
                        end
                end
        end
endmodule

`default_nettype wire

/* hdl/wb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter #(
        parameter int NUM_MASTERS = 5
) (
        input  logic                              clk,
        input  logic                              reset,
        input  logic [NUM_MASTERS-1:0]            m_cyc,
        input  logic [NUM_MASTERS-1:0]            m_stb,
        input  logic [NUM_MASTERS-1:0]            m_we,
        input  lstm_pkg::addr_t [NUM_MASTERS-1:0] m_adr,
        input  lstm_pkg::data_t [NUM_MASTERS-1:0] m_dat_w,
        output lstm_pkg::data_t [NUM_MASTERS-1:0] m_dat_r,
        output logic [NUM_MASTERS-1:0]            m_ack,
        output logic                              s_cyc,
        output logic                              s_stb,
        output logic                              s_we,
        output lstm_pkg::addr_t                   s_adr,
        output lstm_pkg::data_t                   s_dat_w,
        input  lstm_pkg::data_t                   s_dat_r,
        input  logic                              s_ack
);
        localparam int GW = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

        logic [GW-1:0] grant;
        logic [GW-1:0] next_grant;

        // nearest requester after the current owner wins
        always_comb
        begin
                int cand;
                next_grant = grant;
                for (int k = NUM_MASTERS; k >= 1; k--)
                begin
                        cand = (int'(grant) + k) % NUM_MASTERS;
                        if (m_cyc[cand])
                                next_grant = GW'(cand);
                end
        end

        always_ff @(posedge clk)
        begin
                if (reset)
                        grant <= '0;
                else if (!m_cyc[grant])
                        grant <= next_grant;            // owner let go of cyc
        end

        assign s_cyc   = m_cyc[grant];
        assign s_stb   = m_stb[grant];
        assign s_we    = m_we[grant];
        assign s_adr   = m_adr[grant];
        assign s_dat_w = m_dat_w[grant];
        assign m_dat_r = {NUM_MASTERS{s_dat_r}};

        always_comb
        begin
                m_ack        = '0;
                m_ack[grant] = s_ack;                   // the rest keep waiting
        end
endmodule

`default_nettype wire

/* hdl/gate_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module gate_mac #(
        parameter int VEC_LEN    = 4,
        parameter int GATE_BASE  = 0,
        parameter int INPUT_BASE = 48
) (
        input  logic            clk,
        input  logic            reset,
        input  logic            launch,
        output logic            wb_cyc,
        output logic            wb_stb,
        output logic            wb_we,
        output lstm_pkg::addr_t wb_adr,
        output lstm_pkg::data_t wb_dat_w,
        input  lstm_pkg::data_t wb_dat_r,
        input  logic            wb_ack,
        output lstm_pkg::data_t gate_value,
        output logic            gate_done
);
        lstm_pkg::gate_state_t state;
        logic [3:0]            idx;
        logic                  last_idx;
        lstm_pkg::data_t       weight_r;
        lstm_pkg::data_t       input_r;
        lstm_pkg::acc_t        acc;
        lstm_pkg::acc_t        product;
        logic signed [32:0]    acc_wide;
        lstm_pkg::acc_t        acc_sat;

        assign last_idx = (idx == 4'(VEC_LEN - 1));
        assign product  = weight_r * input_r;
        assign acc_wide = {acc[31], acc} + {product[31], product};
        assign acc_sat  = (acc_wide[32] != acc_wide[31]) ?
                          {acc_wide[32], {31{~acc_wide[32]}}} : acc_wide[31:0];

        // bus side decoded from the state, cyc held for the whole run
        always_comb
        begin
                wb_cyc = 1'b1;
                wb_stb = 1'b1;
                wb_adr = '0;
                case (state)
                lstm_pkg::gs_fetch_bias:   wb_adr = lstm_pkg::addr_t'(GATE_BASE);
                lstm_pkg::gs_fetch_weight: wb_adr = lstm_pkg::addr_t'(GATE_BASE + 1 + idx);
                lstm_pkg::gs_fetch_input:  wb_adr = lstm_pkg::addr_t'(INPUT_BASE + idx);
                lstm_pkg::gs_accumulate:   wb_stb = 1'b0;
                default:
                begin
                        wb_cyc = 1'b0;
                        wb_stb = 1'b0;
                end
                endcase
        end

        assign wb_we    = 1'b0;                         // read only master
        assign wb_dat_w = '0;

        // last product shows up the cycle after the final input ack
        assign gate_done  = (state == lstm_pkg::gs_accumulate) && last_idx;
        assign gate_value = lstm_pkg::q_from_acc((state == lstm_pkg::gs_accumulate) ?
                                                 acc_sat : acc);

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        state <= lstm_pkg::gs_idle;
                        idx   <= '0;
                end
                else
                begin
                        case (state)
                        lstm_pkg::gs_idle:
                                if (launch)
                                        state <= lstm_pkg::gs_fetch_bias;
                        lstm_pkg::gs_fetch_bias:
                                if (wb_ack)
                                begin
                                        acc   <= {{4{wb_dat_r[15]}}, wb_dat_r, 12'h000};
                                        idx   <= '0;
                                        state <= lstm_pkg::gs_fetch_weight;
                                end
                        lstm_pkg::gs_fetch_weight:
                                if (wb_ack)
                                begin
                                        weight_r <= wb_dat_r;
                                        state    <= lstm_pkg::gs_fetch_input;
                                end
                        lstm_pkg::gs_fetch_input:
                                if (wb_ack)
                                begin
                                        input_r <= wb_dat_r;
                                        state   <= lstm_pkg::gs_accumulate;
                                end
                        lstm_pkg::gs_accumulate:
                        begin
                                acc   <= acc_sat;
                                idx   <= idx + 4'd1;
                                state <= last_idx ? lstm_pkg::gs_finish :
                                                    lstm_pkg::gs_fetch_weight;
                        end
                        default:
                                state <= lstm_pkg::gs_idle;
                        endcase
                end
        end
endmodule

`default_nettype wire

/* hdl/cell_state_update.sv */
`timescale 1ns/1ps
`default_nettype none

module cell_state_update (
        input  logic            clk,
        input  logic            reset,
        input  logic            start,
        input  lstm_pkg::data_t gate_i,
        input  lstm_pkg::data_t gate_f,
        input  lstm_pkg::data_t gate_g,
        input  lstm_pkg::data_t gate_o,
        input  logic [3:0]      gate_done,
        output logic            launch,
        output logic            busy,
        output logic            done,
        output lstm_pkg::data_t c_out,
        output lstm_pkg::data_t h_out
);
        lstm_pkg::data_t sig_i;
        lstm_pkg::data_t sig_f;
        lstm_pkg::data_t sig_o;
        lstm_pkg::data_t tanh_g;
        lstm_pkg::data_t tanh_c;
        lstm_pkg::data_t c_new;
        lstm_pkg::data_t h_new;
        logic [3:0]      flags;
        logic            all_in;

        sigmoid u_sig_i (.x(gate_i), .sig_out(sig_i));
        sigmoid u_sig_f (.x(gate_f), .sig_out(sig_f));
        sigmoid u_sig_o (.x(gate_o), .sig_out(sig_o));
        tanh_unit u_tanh_g (.x(gate_g), .tanh_out(tanh_g));
        tanh_unit u_tanh_c (.x(c_new), .tanh_out(tanh_c));

        // c_out doubles as the stored cell state
        assign c_new  = lstm_pkg::q_add_sat(lstm_pkg::q_mul(sig_f, c_out),
                                            lstm_pkg::q_mul(sig_i, tanh_g));
        assign h_new  = lstm_pkg::q_mul(sig_o, tanh_c);
        assign all_in = &(flags | gate_done);

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        busy   <= 1'b0;
                        launch <= 1'b0;
                        done   <= 1'b0;
                        flags  <= '0;
                        c_out  <= '0;
                        h_out  <= '0;
                end
                else
                begin
                        launch <= 1'b0;
                        done   <= 1'b0;
                        if (!busy)
                        begin
                                if (start)
                                begin
                                        busy   <= 1'b1;
                                        launch <= 1'b1;
                                        flags  <= '0;
                                end
                        end
                        else if (all_in)
                        begin
                                busy  <= 1'b0;          // drops with done
                                done  <= 1'b1;
                                c_out <= c_new;
                                h_out <= h_new;
                        end
                        else
                                flags <= flags | gate_done;
                end
        end
endmodule

`default_nettype wire

/* hdl/lstm_cell_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lstm_cell_top #(
        parameter int VEC_LEN     = 4,
        parameter int INPUT_BASE  = 48,
        parameter int NUM_MASTERS = 5
) (
        input  logic            clk,
        input  logic            reset,
        input  logic            start,
        output logic            busy,
        output logic            done,
        output lstm_pkg::data_t c_out,
        output lstm_pkg::data_t h_out,
        input  logic            host_cyc,
        input  logic            host_stb,
        input  logic            host_we,
        input  lstm_pkg::addr_t host_adr,
        input  lstm_pkg::data_t host_dat_w,
        output lstm_pkg::data_t host_dat_r,
        output logic            host_ack
);
        localparam int REGION = 12;                     // words per gate region

        wire [NUM_MASTERS-1:0]                 m_cyc;
        wire [NUM_MASTERS-1:0]                 m_stb;
        wire [NUM_MASTERS-1:0]                 m_we;
        wire [NUM_MASTERS-1:0]                 m_ack;
        wire lstm_pkg::addr_t [NUM_MASTERS-1:0] m_adr;
        wire lstm_pkg::data_t [NUM_MASTERS-1:0] m_dat_w;
        wire lstm_pkg::data_t [NUM_MASTERS-1:0] m_dat_r;
        wire                                   s_cyc;
        wire                                   s_stb;
        wire                                   s_we;
        wire                                   s_ack;
        wire lstm_pkg::addr_t                  s_adr;
        wire lstm_pkg::data_t                  s_dat_w;
        wire lstm_pkg::data_t                  s_dat_r;
        wire                                   launch;
        wire [3:0]                             gate_done;
        wire lstm_pkg::data_t [3:0]            gate_val;      // i, f, g, o

        // host is master 0
        assign m_cyc[0]   = host_cyc;
        assign m_stb[0]   = host_stb;
        assign m_we[0]    = host_we;
        assign m_adr[0]   = host_adr;
        assign m_dat_w[0] = host_dat_w;
        assign host_dat_r = m_dat_r[0];
        assign host_ack   = m_ack[0];

        wb_arbiter #(.NUM_MASTERS(NUM_MASTERS)) u_arb (
                .clk (clk), .reset (reset),
                .m_cyc (m_cyc), .m_stb (m_stb), .m_we (m_we), .m_adr (m_adr),
                .m_dat_w (m_dat_w), .m_dat_r (m_dat_r), .m_ack (m_ack),
                .s_cyc (s_cyc), .s_stb (s_stb), .s_we (s_we), .s_adr (s_adr),
                .s_dat_w (s_dat_w), .s_dat_r (s_dat_r), .s_ack (s_ack)
        );

        weight_mem u_mem (
                .clk (clk), .reset (reset), .cyc (s_cyc), .stb (s_stb), .we (s_we),
                .adr (s_adr), .dat_w (s_dat_w), .dat_r (s_dat_r), .ack (s_ack)
        );

        for (genvar k = 0; k < 4; k++)
        begin : g_gate
                gate_mac #(
                        .VEC_LEN    (VEC_LEN),
                        .GATE_BASE  (REGION * k),
                        .INPUT_BASE (INPUT_BASE)
                ) u_gate (
                        .clk (clk), .reset (reset), .launch (launch),
                        .wb_cyc (m_cyc[k + 1]), .wb_stb (m_stb[k + 1]), .wb_we (m_we[k + 1]),
                        .wb_adr (m_adr[k + 1]), .wb_dat_w (m_dat_w[k + 1]),
                        .wb_dat_r (m_dat_r[k + 1]), .wb_ack (m_ack[k + 1]),
                        .gate_value (gate_val[k]), .gate_done (gate_done[k])
                );
        end

        cell_state_update u_csu (
                .clk (clk), .reset (reset), .start (start),
                .gate_i (gate_val[0]), .gate_f (gate_val[1]),
                .gate_g (gate_val[2]), .gate_o (gate_val[3]),
                .gate_done (gate_done), .launch (launch), .busy (busy), .done (done),
                .c_out (c_out), .h_out (h_out)
        );
endmodule

`default_nettype wire

/* bench/lstm_cell_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module lstm_cell_assert #(
        parameter int NUM_MASTERS = 5
) (
        input  wire                   clk,
        input  wire                   reset,
        input  wire                   s_cyc,
        input  wire                   s_stb,
        input  wire                   s_ack,
        input  wire [NUM_MASTERS-1:0] m_ack,
        input  wire                   busy,
        input  wire                   done
);
        // slave ack answers a request seen one edge earlier
        ack_follows_req: assert property (@(posedge clk) disable iff (reset)
                s_ack |-> $past(s_cyc && s_stb))
                else $error("slave ack without a request");

        one_master_ack: assert property (@(posedge clk) disable iff (reset)
                $onehot0(m_ack))
                else $error("more than one master sees ack");

        done_in_busy: assert property (@(posedge clk) disable iff (reset)
                done |-> $past(busy))
                else $error("done outside a busy step");
endmodule

bind lstm_cell_top lstm_cell_assert #(.NUM_MASTERS(NUM_MASTERS)) u_assert (
        .clk (clk), .reset (reset), .s_cyc (s_cyc), .s_stb (s_stb), .s_ack (s_ack),
        .m_ack (m_ack), .busy (busy), .done (done)
);

`default_nettype wire

/* bench/lstm_cell_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lstm_cell_tb;
        localparam int VEC_LEN    = 4;
        localparam int INPUT_BASE = 48;
        localparam int REGION     = 12;                 // words per gate region
        localparam int NUM_STEPS  = 5;
        localparam int LIMIT      = NUM_STEPS * 200 + 400;      // steps, reset and memory test

        logic            clk;
        logic            reset;
        logic            start;
        logic            busy;
        logic            done;
        lstm_pkg::data_t c_out;
        lstm_pkg::data_t h_out;
        logic            host_cyc;
        logic            host_stb;
        logic            host_we;
        lstm_pkg::addr_t host_adr;
        lstm_pkg::data_t host_dat_w;
        lstm_pkg::data_t host_dat_r;
        logic            host_ack;
        int              done_count;
        int              cycles;

        // input vector x0..x3 per step
        lstm_pkg::data_t x_tab [NUM_STEPS][4] = '{
                '{16'h1000, 16'h0800, 16'hf000, 16'h2000},
                '{16'h0400, 16'hfc00, 16'h7fff, 16'h8000},
                '{16'h7000, 16'h7000, 16'h7000, 16'h7000},
                '{16'h1000, 16'h0800, 16'hf800, 16'h0000},
                '{16'h1000, 16'h0800, 16'hf800, 16'h0000}
        };
        // biases in gate order i, f, g, o
        lstm_pkg::data_t bias_tab [NUM_STEPS][4] = '{
                '{16'h1000, 16'h0000, 16'h0800, 16'h2000},
                '{16'hc000, 16'h4000, 16'h3000, 16'h5000},     // both saturation ends
                '{16'h0000, 16'h0000, 16'h0000, 16'h0000},
                '{16'h0000, 16'h1000, 16'hf000, 16'h0000},
                '{16'h0000, 16'h1000, 16'hf000, 16'h0000}
        };
        // one weight row per gate
        lstm_pkg::data_t w_tab [NUM_STEPS][4][4] = '{
                '{'{16'h0000, 16'h0000, 16'h0000, 16'h0000},
                  '{16'h0000, 16'h0000, 16'h0000, 16'h0000},
                  '{16'h0000, 16'h0000, 16'h0000, 16'h0000},
                  '{16'h0000, 16'h0000, 16'h0000, 16'h0000}},
                '{'{16'h0000, 16'h0000, 16'h0000, 16'h0000},
                  '{16'h0000, 16'h0000, 16'h0000, 16'h0000},
                  '{16'h0000, 16'h0000, 16'h0000, 16'h0000},
                  '{16'h0000, 16'h0000, 16'h0000, 16'h0000}},
                '{'{16'h7000, 16'h7000, 16'h7000, 16'h7000},  // dot product clamps high
                  '{16'h9000, 16'h9000, 16'h9000, 16'h9000},  // clamps low
                  '{16'h9000, 16'h9000, 16'h9000, 16'h9000},
                  '{16'h0100, 16'h0100, 16'h0100, 16'h0100}},
                '{'{16'h0800, 16'h1000, 16'h0000, 16'h0000},
                  '{16'h0000, 16'h0000, 16'h1000, 16'h0000},
                  '{16'h0000, 16'h0000, 16'h0000, 16'h4000},
                  '{16'h1000, 16'h1000, 16'h1000, 16'h1000}},
                '{'{16'h0800, 16'h1000, 16'h0000, 16'h0000},
                  '{16'h0000, 16'h0000, 16'h1000, 16'h0000},
                  '{16'h0000, 16'h0000, 16'h0000, 16'h4000},
                  '{16'h1000, 16'h1000, 16'h1000, 16'h1000}}
        };
        // c carries over from one step to the next
        lstm_pkg::data_t exp_c_tab [NUM_STEPS] = '{16'h0602, 16'h0602, 16'hf000, 16'hed28, 16'heb62};
        lstm_pkg::data_t exp_h_tab [NUM_STEPS] = '{16'h04c9, 16'h0560, 16'hf5fc, 16'hf62e, 16'hf5d0};
        logic            poke_tab  [NUM_STEPS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

        lstm_cell_top #(
                .VEC_LEN     (VEC_LEN),
                .INPUT_BASE  (INPUT_BASE),
                .NUM_MASTERS (5)
        ) lstm_cell_top_inst (
                .clk (clk), .reset (reset), .start (start), .busy (busy), .done (done),
                .c_out (c_out), .h_out (h_out),
                .host_cyc (host_cyc), .host_stb (host_stb), .host_we (host_we),
                .host_adr (host_adr), .host_dat_w (host_dat_w),
                .host_dat_r (host_dat_r), .host_ack (host_ack)
        );

        initial
        begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        always @(negedge clk)
        begin
                if (done)
                        done_count++;                   // done is stable here
        end

        always @(posedge clk)
        begin
                cycles++;
                if (cycles >= LIMIT)
                begin
                        $display("Timeout: the run did not finish within %0d cycles", LIMIT);
                        $display("Test failures found");
                        $fatal(1, "simulation stopped by the cycle limit");
                end
        end

        task automatic report_fail(input string msg);
                $display("Fail at %0t ns: %s", $time, msg);
                $display("Test failures found");
                $fatal(1, "stopped at the first mismatch");
        endtask

        task automatic check_data(input string what, input lstm_pkg::data_t got,
                                  input lstm_pkg::data_t exp);
                if (got !== exp)
                        report_fail($sformatf("%s is %h, expected %h", what, got, exp));
        endtask

        task automatic check_flag(input string what, input logic got, input logic exp);
                if (got !== exp)
                        report_fail($sformatf("%s is %b, expected %b", what, got, exp));
        endtask

        // one classic cycle, held until the ack shows up
        task automatic bus_access(input logic write, input lstm_pkg::addr_t adr,
                                  input lstm_pkg::data_t wdata, output lstm_pkg::data_t rdata);
                @(posedge clk);
                #2;
                host_cyc   = 1'b1;
                host_stb   = 1'b1;
                host_we    = write;
                host_adr   = adr;
                host_dat_w = wdata;
                @(posedge clk);
                #2;
                while (!host_ack)
                begin
                        @(posedge clk);
                        #2;
                end
                rdata    = host_dat_r;
                host_cyc = 1'b0;                        // lets the arbiter rotate
                host_stb = 1'b0;
                host_we  = 1'b0;
        endtask

        task automatic host_write(input lstm_pkg::addr_t adr, input lstm_pkg::data_t wdata);
                lstm_pkg::data_t ignored;
                bus_access(1'b1, adr, wdata, ignored);
        endtask

        task automatic host_read(input lstm_pkg::addr_t adr, output lstm_pkg::data_t rdata);
                bus_access(1'b0, adr, '0, rdata);
        endtask

        task automatic load_step(input int k);
                for (int g = 0; g < 4; g++)
                begin
                        host_write(lstm_pkg::addr_t'(REGION * g), bias_tab[k][g]);
                        for (int j = 0; j < VEC_LEN; j++)
                                host_write(lstm_pkg::addr_t'(REGION * g + 1 + j), w_tab[k][g][j]);
                end
                for (int j = 0; j < VEC_LEN; j++)
                        host_write(lstm_pkg::addr_t'(INPUT_BASE + j), x_tab[k][j]);
        endtask

        task automatic pulse_start();
                @(posedge clk);
                #2;
                start = 1'b1;
                @(posedge clk);
                #2;
                start = 1'b0;
        endtask

        task automatic wait_for_done(input int target);
                while (done_count < target)
                begin
                        @(posedge clk);
                        #2;
                end
        endtask

        initial
        begin
                lstm_pkg::data_t shadow [64];
                lstm_pkg::addr_t a;
                lstm_pkg::data_t v;
                lstm_pkg::data_t rd;

                void'($urandom(32'h5436c0cc));
                reset      = 1'b1;
                start      = 1'b0;
                host_cyc   = 1'b0;
                host_stb   = 1'b0;
                host_we    = 1'b0;
                host_adr   = '0;
                host_dat_w = '0;
                done_count = 0;
                cycles     = 0;
                repeat (16) @(posedge clk);
                #2;
                reset = 1'b0;

                // outputs come out of reset idle and cleared
                check_flag("busy after reset", busy, 1'b0);
                check_flag("done after reset", done, 1'b0);
                check_flag("host_ack after reset", host_ack, 1'b0);
                check_data("c_out after reset", c_out, 16'h0000);
                check_data("h_out after reset", h_out, 16'h0000);

                // random writes, then every word against the mirror
                for (int k = 0; k < 64; k++)
                        shadow[k] = '0;
                for (int n = 0; n < 8; n++)
                begin
                        a = lstm_pkg::addr_t'($urandom % 64);
                        v = lstm_pkg::data_t'($urandom);
                        host_write(a, v);
                        shadow[a] = v;
                end
                for (int k = 0; k < 64; k++)
                begin
                        host_read(lstm_pkg::addr_t'(k), rd);
                        check_data($sformatf("memory word %0d", k), rd, shadow[k]);
                end

                for (int k = 0; k < NUM_STEPS; k++)
                begin
                        load_step(k);
                        check_flag("busy before start", busy, 1'b0);
                        pulse_start();
                        check_flag("busy after start", busy, 1'b1);
                        if (poke_tab[k])
                        begin
                                pulse_start();          // must be ignored
                                check_flag("busy after second start", busy, 1'b1);
                                host_read(lstm_pkg::addr_t'(INPUT_BASE), rd);
                                check_data("host read while busy", rd, x_tab[k][0]);
                        end
                        wait_for_done(k + 1);
                        check_data($sformatf("c_out of step %0d", k), c_out, exp_c_tab[k]);
                        check_data($sformatf("h_out of step %0d", k), h_out, exp_h_tab[k]);
                        check_flag("busy after done", busy, 1'b0);
                        repeat (4) @(posedge clk);
                        #2;
                        check_flag("busy stays low", busy, 1'b0);
                        check_flag("one done per step", done_count == k + 1, 1'b1);
                end

                $display("All tests passed!");
                $finish;
        end
endmodule

`default_nettype wire

/* lstm_cell.f */
hdl/lstm_pkg.sv
hdl/sigmoid.sv
hdl/tanh_unit.sv
hdl/weight_mem.sv
hdl/wb_arbiter.sv
hdl/gate_mac.sv
hdl/cell_state_update.sv
hdl/lstm_cell_top.sv
bench/lstm_cell_assert.sv
bench/lstm_cell_tb.sv

/* Makefile */
# Verilator build and run for the LSTM cell testbench

VERILATOR ?= verilator
TOP       ?= lstm_cell_tb
FILELIST  ?= lstm_cell.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
